// ==== bp_btb.sv ====
/* Direct-mapped tagged branch target buffer, combinational lookup
   and fill on taken retiring branches */

`timescale 1ns/1ps
`default_nettype none

module bp_btb #(
    parameter int BTB_BITS     = 6,
    parameter int BTB_TAG_BITS = 10
) (
    input  logic      clock,
    input  logic      reset,

    // Prediction side
    bp_lookup_if.btb  lookup,

    // Retire side
    bp_update_if.btb  update
);

    localparam int BTB_ENTRIES = 1 << BTB_BITS;

    // Bit position where the tag starts
    localparam int TAG_LSB = bp_pkg::PC_ALIGN_BITS + BTB_BITS;

    // One buffer line
    typedef struct packed {
        logic                    valid;
        logic [BTB_TAG_BITS-1:0] tag;
        logic [bp_pkg::XLEN-1:0] target;
    } btb_entry_t;

    btb_entry_t btb_mem [BTB_ENTRIES];

    // Lookup fields
    logic [BTB_BITS-1:0]     lookup_idx;
    logic [BTB_TAG_BITS-1:0] lookup_tag;
    btb_entry_t              lookup_entry;

    // Fill fields
    logic [BTB_BITS-1:0]     fill_idx;
    logic [BTB_TAG_BITS-1:0] fill_tag;
    logic                    fill_en;

    ////////////////////
    // Address split
    ////////////////////

    // Index just above the alignment bits
    assign lookup_idx = lookup.pc[bp_pkg::PC_ALIGN_BITS +: BTB_BITS];
    assign fill_idx   = update.pc[bp_pkg::PC_ALIGN_BITS +: BTB_BITS];

    // Tag from the bits above the index
    assign lookup_tag = lookup.pc[TAG_LSB +: BTB_TAG_BITS];
    assign fill_tag   = update.pc[TAG_LSB +: BTB_TAG_BITS];

    ////////////////////
    // Lookup
    ////////////////////

    assign lookup_entry = btb_mem[lookup_idx];

    // Hit needs a live line with a matching tag
    assign lookup.btb_hit    = lookup_entry.valid && (lookup_entry.tag == lookup_tag);
    assign lookup.btb_target = lookup_entry.target;

    ////////////////////
    // Fill
    ////////////////////

    // Only taken branches carry a useful target
    assign fill_en = update.valid && update.actual_taken;

    always_ff @(posedge clock) begin
        if (reset) begin
            // Invalidate all lines
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                btb_mem[i].valid <= 1'b0;
            end
        end else if (fill_en) begin
            // Overwrites whatever held this index before
            btb_mem[fill_idx].valid  <= 1'b1;
            btb_mem[fill_idx].tag    <= fill_tag;
            btb_mem[fill_idx].target <= update.actual_target;
        end
    end

endmodule

`default_nettype wire

// ==== bp_ctrl.sv ====
/* Predictor control: global history register, fetch ready gating
   during mispredict recovery, prediction response assembly */

`timescale 1ns/1ps
`default_nettype none

module bp_ctrl #(
    parameter int GHR_WIDTH = 8
) (
    input  logic                    clock,
    input  logic                    reset,

    // Fetch request
    input  logic                    predict_valid_i,
    input  logic [bp_pkg::XLEN-1:0] predict_pc_i,
    output logic                    predict_ready_o,

    // Prediction response, same cycle as the request
    output logic                    predict_resp_valid_o,
    output logic                    predict_taken_o,
    output logic [bp_pkg::XLEN-1:0] predict_target_o,
    output logic [GHR_WIDTH-1:0]    predict_ghr_snapshot_o,

    // Retire side, only what the history needs
    input  logic                    train_valid_i,
    input  logic                    train_mispredict_i,
    input  logic [GHR_WIDTH-1:0]    train_ghr_snapshot_i,
    input  logic                    train_actual_taken_i,

    // Combinational lookup into PHT and BTB
    bp_lookup_if.ctrl               lookup
);

    // Sequential fall-through distance
    localparam logic [bp_pkg::XLEN-1:0] INSN_BYTES = bp_pkg::XLEN'(1) << bp_pkg::PC_ALIGN_BITS;

    // Speculative global history
    logic [GHR_WIDTH-1:0] ghr;
    logic [GHR_WIDTH-1:0] ghr_next;

    logic recovery;
    logic accept;

    ////////////////////
    // Handshake
    ////////////////////

    // Retire overwrites the GHR this cycle
    assign recovery = train_valid_i && train_mispredict_i;

    // Hold fetch off for the one recovery cycle
    assign predict_ready_o = !recovery;

    // Request taken when both sides agree
    assign accept = predict_valid_i && predict_ready_o;

    assign predict_resp_valid_o = accept;

    ////////////////////
    // Lookup drive
    ////////////////////

    assign lookup.pc  = predict_pc_i;
    assign lookup.ghr = ghr;

    ////////////////////
    // Response
    ////////////////////

    // Direction straight from the PHT
    assign predict_taken_o = lookup.pht_taken;

    // BTB target on hit, else next sequential instruction
    assign predict_target_o = lookup.btb_hit ? lookup.btb_target
                                             : predict_pc_i + INSN_BYTES;

    // History before this prediction shifts in
    assign predict_ghr_snapshot_o = ghr;

    ////////////////////
    // History update
    ////////////////////

    always_comb begin
        // Default hold
        ghr_next = ghr;
        if (recovery) begin
            // Rebuild from the snapshot plus the real outcome
            ghr_next = {train_ghr_snapshot_i[GHR_WIDTH-2:0], train_actual_taken_i};
        end else if (accept) begin
            // Speculative shift with the predicted direction
            ghr_next = {ghr[GHR_WIDTH-2:0], lookup.pht_taken};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ghr <= '0;
        end else begin
            ghr <= ghr_next;
        end
    end

endmodule

`default_nettype wire

// ==== bp_if.sv ====
/* Lookup interface between control, PHT and BTB, and the retire
   training interface feeding PHT and BTB */

`timescale 1ns/1ps
`default_nettype none

////////////////////
// Lookup path
////////////////////

// Purely combinational, no handshake inside the subsystem
interface bp_lookup_if #(
    parameter int GHR_WIDTH = 8
);

    // Request side from control
    logic [bp_pkg::XLEN-1:0] pc;
    logic [GHR_WIDTH-1:0]    ghr;

    // Direction from the PHT
    logic                    pht_taken;

    // Target from the BTB
    logic                    btb_hit;
    logic [bp_pkg::XLEN-1:0] btb_target;

    // Control drives the lookup and collects both answers
    modport ctrl (
        output pc,
        output ghr,
        input  pht_taken,
        input  btb_hit,
        input  btb_target
    );

    // Gshare index needs PC and history
    modport pht (
        input  pc,
        input  ghr,
        output pht_taken
    );

    // BTB is indexed by PC only
    modport btb (
        input  pc,
        output btb_hit,
        output btb_target
    );

endinterface

////////////////////
// Training path
////////////////////

// Valid only, retire is never stalled
interface bp_update_if #(
    parameter int GHR_WIDTH = 8
);

    logic                    valid;
    logic [bp_pkg::XLEN-1:0] pc;
    // History the branch was predicted under
    logic [GHR_WIDTH-1:0]    ghr_snapshot;
    logic                    actual_taken;
    logic [bp_pkg::XLEN-1:0] actual_target;

    modport source (
        output valid,
        output pc,
        output ghr_snapshot,
        output actual_taken,
        output actual_target
    );

    // Counter training
    modport pht (
        input valid,
        input pc,
        input ghr_snapshot,
        input actual_taken
    );

    // Target fill on taken branches
    modport btb (
        input valid,
        input pc,
        input actual_taken,
        input actual_target
    );

endinterface

`default_nettype wire

// ==== bp_pht.sv ====
/* Gshare pattern history table of two-bit saturating counters,
   combinational lookup and retire-time training */

`timescale 1ns/1ps
`default_nettype none

module bp_pht #(
    parameter int GHR_WIDTH = 8,
    // Must cover the full history
    parameter int PHT_BITS  = 10
) (
    input  logic      clock,
    input  logic      reset,

    // Prediction side
    bp_lookup_if.pht  lookup,

    // Retire side
    bp_update_if.pht  update
);

    localparam int PHT_ENTRIES = 1 << PHT_BITS;

    // Counter storage
    bp_pkg::counter_t pht_mem [PHT_ENTRIES];

    logic [PHT_BITS-1:0] lookup_idx;
    logic [PHT_BITS-1:0] train_idx;

    bp_pkg::counter_t    lookup_cnt;
    logic [1:0]          lookup_raw;

    ////////////////////
    // Index hash
    ////////////////////

    // Word-aligned PC bits xor zero-extended history
    function automatic logic [PHT_BITS-1:0] gshare_index(
        input logic [bp_pkg::XLEN-1:0] pc,
        input logic [GHR_WIDTH-1:0]    hist
    );
        logic [PHT_BITS-1:0] pc_bits;
        logic [PHT_BITS-1:0] hist_ext;
        pc_bits  = pc[bp_pkg::PC_ALIGN_BITS +: PHT_BITS];
        hist_ext = PHT_BITS'(hist);
        return pc_bits ^ hist_ext;
    endfunction

    assign lookup_idx = gshare_index(lookup.pc, lookup.ghr);
    assign train_idx  = gshare_index(update.pc, update.ghr_snapshot);

    ////////////////////
    // Lookup
    ////////////////////

    assign lookup_cnt = pht_mem[lookup_idx];
    assign lookup_raw = lookup_cnt;

    // Upper counter bit is the direction
    assign lookup.pht_taken = lookup_raw[1];

    ////////////////////
    // Training
    ////////////////////

    // Visible to lookups from the next cycle on
    always_ff @(posedge clock) begin
        if (reset) begin
            // Every counter starts strongly not taken
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_mem[i] <= bp_pkg::STRONG_NOT_TAKEN;
            end
        end else if (update.valid) begin
            pht_mem[train_idx] <= bp_pkg::next_counter(pht_mem[train_idx],
                                                       update.actual_taken);
        end
    end

endmodule

`default_nettype wire

// ==== bp_pkg.sv ====
/* Shared branch predictor definitions: address width, PC alignment,
   two-bit counter type and its saturating update function */

`default_nettype none

package bp_pkg;

    ////////////////////
    // Address constants
    ////////////////////

    // Instruction address width
    parameter int XLEN = 32;

    // Low PC bits that are always zero for word-aligned instructions
    parameter int PC_ALIGN_BITS = 2;

    ////////////////////
    // Direction counter
    ////////////////////

    // Upper bit gives the predicted direction
    typedef enum logic [1:0] {
        STRONG_NOT_TAKEN = 2'd0,
        WEAK_NOT_TAKEN   = 2'd1,
        WEAK_TAKEN       = 2'd2,
        STRONG_TAKEN     = 2'd3
    } counter_t;

    // Step one state toward the outcome, saturating at both ends
    function automatic counter_t next_counter(input counter_t state, input logic taken);
        counter_t result;
        case (state)
            STRONG_NOT_TAKEN: result = taken ? WEAK_NOT_TAKEN : STRONG_NOT_TAKEN;
            WEAK_NOT_TAKEN:   result = taken ? WEAK_TAKEN     : STRONG_NOT_TAKEN;
            WEAK_TAKEN:       result = taken ? STRONG_TAKEN   : WEAK_NOT_TAKEN;
            STRONG_TAKEN:     result = taken ? STRONG_TAKEN   : WEAK_TAKEN;
            // X on the stored state, fall back to the reset value
            default:          result = STRONG_NOT_TAKEN;
        endcase
        return result;
    endfunction

endpackage

`default_nettype wire

// ==== bp_tb.sv ====
/* Branch predictor testbench: clock, reset, stimulus and expectation
   table, value check, watchdog and per-test summary */

`timescale 1ns/1ps
`default_nettype none

module bp_tb;

    localparam int PERIOD       = 20;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 2;
    // Sample point, a few ns before the next rising edge
    localparam int CHECK_DELAY  = 15;
    localparam int GHR_WIDTH    = 8;
    localparam int NUM_ROWS     = 24;
    localparam int TIMEOUT_NS   = (NUM_ROWS + RESET_CYCLES) * 2 * PERIOD + 200;

    ////////////////////
    // Table layout
    ////////////////////

    // Stimulus first, expected response after it
    typedef struct packed {
        logic [7:0]           test_id;
        logic                 pv;
        logic [31:0]          pc;
        logic                 tv;
        logic [31:0]          tpc;
        logic [GHR_WIDTH-1:0] tghr;
        logic                 mis;
        logic                 ttaken;
        logic [31:0]          ttarget;
        logic                 exp_ready;
        logic                 exp_rv;
        logic                 exp_taken;
        logic [31:0]          exp_target;
        logic [GHR_WIDTH-1:0] exp_snap;
    } row_t;

    row_t rows [NUM_ROWS];
    int   row_count;

    // DUT signals
    logic                 clock;
    logic                 reset;
    logic                 predict_valid;
    logic [31:0]          predict_pc;
    logic                 predict_ready;
    logic                 predict_resp_valid;
    logic                 predict_taken;
    logic [31:0]          predict_target;
    logic [GHR_WIDTH-1:0] predict_ghr_snapshot;
    logic                 train_valid;
    logic [31:0]          train_pc;
    logic [GHR_WIDTH-1:0] train_ghr_snapshot;
    logic                 train_mispredict;
    logic                 train_actual_taken;
    logic [31:0]          train_actual_target;

    // Score keeping
    int error_count;
    int check_count;
    int test_errors;
    int test_checks;

    bp_top dut_i (
        .clock                  (clock),
        .reset                  (reset),
        .predict_valid_i        (predict_valid),
        .predict_pc_i           (predict_pc),
        .predict_ready_o        (predict_ready),
        .predict_resp_valid_o   (predict_resp_valid),
        .predict_taken_o        (predict_taken),
        .predict_target_o       (predict_target),
        .predict_ghr_snapshot_o (predict_ghr_snapshot),
        .train_valid_i          (train_valid),
        .train_pc_i             (train_pc),
        .train_ghr_snapshot_i   (train_ghr_snapshot),
        .train_mispredict_i     (train_mispredict),
        .train_actual_taken_i   (train_actual_taken),
        .train_actual_target_i  (train_actual_target)
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic add_row(input row_t r);
        rows[row_count] = r;
        row_count++;
    endtask

    task automatic drive_row(input row_t r);
        predict_valid       = r.pv;
        predict_pc          = r.pc;
        train_valid         = r.tv;
        train_pc            = r.tpc;
        train_ghr_snapshot  = r.tghr;
        train_mispredict    = r.mis;
        train_actual_taken  = r.ttaken;
        train_actual_target = r.ttarget;
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        check_count++;
        test_checks++;
        if (actual !== expected) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, actual, expected);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic check_row(input row_t r);
        compare_value("predict_ready_o", predict_ready, r.exp_ready);
        compare_value("predict_resp_valid_o", predict_resp_valid, r.exp_rv);
        // Response fields only mean something in an accepted cycle
        if (r.exp_rv) begin
            compare_value("predict_taken_o", predict_taken, r.exp_taken);
            compare_value("predict_target_o", predict_target, r.exp_target);
            compare_value("predict_ghr_snapshot_o", predict_ghr_snapshot, r.exp_snap);
        end
    endtask

    task automatic report_test(input int id);
        $display("test %0d: %s (%0d checks, %0d errors)", id,
                 (test_errors == 0) ? "ok" : "failed", test_checks, test_errors);
        test_errors = 0;
        test_checks = 0;
    endtask

    ////////////////////
    // Stimulus table
    ////////////////////

    // test | pv pc | tv tpc tghr mis taken target | ready rv taken target snap
    task automatic build_table();
        // 1: fresh state, not taken and fall-through
        add_row({8'd1, 1'b1, 32'h1000, 1'b0, 32'h0, 8'h00, 1'b0, 1'b0, 32'h0,
                 1'b1, 1'b1, 1'b0, 32'h1004, 8'h00});
        add_row({8'd1, 1'b0, 32'h0, 1'b0, 32'h0, 8'h00, 1'b0, 1'b0, 32'h0,
                 1'b1, 1'b0, 1'b0, 32'h0, 8'h00});
        // 2: PHT index 0x50 goes 0, 1, 2, then back to 1
        add_row({8'd2, 1'b0, 32'h0, 1'b1, 32'h140, 8'h00, 1'b0, 1'b1, 32'h400,
                 1'b1, 1'b0, 1'b0, 32'h0, 8'h00});
        add_row({8'd2, 1'b0, 32'h0, 1'b1, 32'h140, 8'h00, 1'b0, 1'b1, 32'h400,
                 1'b1, 1'b0, 1'b0, 32'h0, 8'h00});
        add_row({8'd2, 1'b1, 32'h140, 1'b1, 32'h140, 8'h00, 1'b0, 1'b0, 32'h0,
                 1'b1, 1'b1, 1'b1, 32'h400, 8'h00});
        // Recovery to a zero history, request held
        add_row({8'd2, 1'b1, 32'h140, 1'b1, 32'h3000, 8'h00, 1'b1, 1'b0, 32'h0,
                 1'b0, 1'b0, 1'b0, 32'h0, 8'h00});
        add_row({8'd2, 1'b1, 32'h140, 1'b0, 32'h0, 8'h00, 1'b0, 1'b0, 32'h0,
                 1'b1, 1'b1, 1'b0, 32'h400, 8'h00});
        // 3: 0x240 shares BTB index 0x10 with 0x140
        add_row({8'd3, 1'b1, 32'h240, 1'b0, 32'h0, 8'h00, 1'b0, 1'b0, 32'h0,
                 1'b1, 1'b1, 1'b0, 32'h244, 8'h00});
        add_row({8'd3, 1'b0, 32'h0, 1'b1, 32'h240, 8'h00, 1'b0, 1'b1, 32'h800,
                 1'b1, 1'b0, 1'b0, 32'h0, 8'h00});
        add_row({8'd3, 1'b1, 32'h240, 1'b0, 32'h0, 8'h00, 1'b0, 1'b0, 32'h0,
                 1'b1, 1'b1, 1'b0, 32'h800, 8'h00});
        add_row({8'd3, 1'b1, 32'h140, 1'b0, 32'h0, 8'h00, 1'b0, 1'b0, 32'h0,
                 1'b1, 1'b1, 1'b0, 32'h144, 8'h00});
        // 4: history 0, 1, 2, idle, idle, 5
        add_row({8'd4, 1'b0, 32'h0, 1'b1, 32'h140, 8'h00, 1'b0, 1'b1, 32'h400,
                 1'b1, 1'b0, 1'b0, 32'h0, 8'h00});
        add_row({8'd4, 1'b1, 32'h140, 1'b0, 32'h0, 8'h00, 1'b0, 1'b0, 32'h0,
                 1'b1, 1'b1, 1'b1, 32'h400, 8'h00});
        add_row({8'd4, 1'b1, 32'h500, 1'b0, 32'h0, 8'h00, 1'b0, 1'b0, 32'h0,
                 1'b1, 1'b1, 1'b0, 32'h504, 8'h01});
        add_row({8'd4, 1'b0, 32'h0, 1'b0, 32'h0, 8'h00, 1'b0, 1'b0, 32'h0,
                 1'b1, 1'b0, 1'b0, 32'h0, 8'h00});
        add_row({8'd4, 1'b0, 32'h0, 1'b0, 32'h0, 8'h00, 1'b0, 1'b0, 32'h0,
                 1'b1, 1'b0, 1'b0, 32'h0, 8'h00});
        // 0x148 xor history 2 lands on index 0x50 again
        add_row({8'd4, 1'b1, 32'h148, 1'b0, 32'h0, 8'h00, 1'b0, 1'b0, 32'h0,
                 1'b1, 1'b1, 1'b1, 32'h14c, 8'h02});
        add_row({8'd4, 1'b1, 32'h500, 1'b0, 32'h0, 8'h00, 1'b0, 1'b0, 32'h0,
                 1'b1, 1'b1, 1'b0, 32'h504, 8'h05});
        // 5: recovery from 0x5a taken, then 0xc3 not taken
        add_row({8'd5, 1'b1, 32'h500, 1'b1, 32'h600, 8'h5a, 1'b1, 1'b1, 32'h700,
                 1'b0, 1'b0, 1'b0, 32'h0, 8'h00});
        add_row({8'd5, 1'b1, 32'h500, 1'b0, 32'h0, 8'h00, 1'b0, 1'b0, 32'h0,
                 1'b1, 1'b1, 1'b0, 32'h504, 8'hb5});
        add_row({8'd5, 1'b1, 32'h500, 1'b1, 32'h600, 8'hc3, 1'b1, 1'b0, 32'h0,
                 1'b0, 1'b0, 1'b0, 32'h0, 8'h00});
        add_row({8'd5, 1'b1, 32'h500, 1'b0, 32'h0, 8'h00, 1'b0, 1'b0, 32'h0,
                 1'b1, 1'b1, 1'b0, 32'h504, 8'h86});
        // Plain training next to a request, ready stays up
        add_row({8'd5, 1'b1, 32'h600, 1'b1, 32'h600, 8'h5a, 1'b0, 1'b1, 32'h700,
                 1'b1, 1'b1, 1'b0, 32'h700, 8'h0c});
        add_row({8'd5, 1'b1, 32'h708, 1'b0, 32'h0, 8'h00, 1'b0, 1'b0, 32'h0,
                 1'b1, 1'b1, 1'b1, 32'h70c, 8'h18});
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int cur_test;
        reset               = 1'b1;
        predict_valid       = 1'b0;
        predict_pc          = '0;
        train_valid         = 1'b0;
        train_pc            = '0;
        train_ghr_snapshot  = '0;
        train_mispredict    = 1'b0;
        train_actual_taken  = 1'b0;
        train_actual_target = '0;
        error_count = 0;
        check_count = 0;
        test_errors = 0;
        test_checks = 0;
        row_count   = 0;
        cur_test    = 0;
        build_table();

        repeat (RESET_CYCLES) @(posedge clock);
        #(DRIVE_DELAY);
        reset = 1'b0;

        // One row per clock cycle
        for (int i = 0; i < row_count; i++) begin
            if (cur_test != 0 && cur_test != rows[i].test_id) begin
                report_test(cur_test);
            end
            cur_test = rows[i].test_id;
            drive_row(rows[i]);
            #(CHECK_DELAY);
            check_row(rows[i]);
            @(posedge clock);
            #(DRIVE_DELAY);
        end
        report_test(cur_test);

        predict_valid = 1'b0;
        train_valid   = 1'b0;
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the table did not finish in %0d ns", TIMEOUT_NS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bp_top.sv ====
/* Branch predictor top level: plain fetch and retire ports,
   lookup and training buses, control, PHT and BTB */

`timescale 1ns/1ps
`default_nettype none

module bp_top #(
    parameter int GHR_WIDTH    = 8,
    // At least GHR_WIDTH
    parameter int PHT_BITS     = 10,
    parameter int BTB_BITS     = 6,
    parameter int BTB_TAG_BITS = 10
) (
    input  logic                    clock,
    input  logic                    reset,

    // Fetch request
    input  logic                    predict_valid_i,
    input  logic [bp_pkg::XLEN-1:0] predict_pc_i,
    output logic                    predict_ready_o,

    // Prediction response
    output logic                    predict_resp_valid_o,
    output logic                    predict_taken_o,
    output logic [bp_pkg::XLEN-1:0] predict_target_o,
    output logic [GHR_WIDTH-1:0]    predict_ghr_snapshot_o,

    // Retire training
    input  logic                    train_valid_i,
    input  logic [bp_pkg::XLEN-1:0] train_pc_i,
    input  logic [GHR_WIDTH-1:0]    train_ghr_snapshot_i,
    input  logic                    train_mispredict_i,
    input  logic                    train_actual_taken_i,
    input  logic [bp_pkg::XLEN-1:0] train_actual_target_i
);

    ////////////////////
    // Internal buses
    ////////////////////

    bp_lookup_if #(.GHR_WIDTH(GHR_WIDTH)) lookup_bus ();
    bp_update_if #(.GHR_WIDTH(GHR_WIDTH)) update_bus ();

    // Retire fields go straight onto the training bus
    assign update_bus.valid         = train_valid_i;
    assign update_bus.pc            = train_pc_i;
    assign update_bus.ghr_snapshot  = train_ghr_snapshot_i;
    assign update_bus.actual_taken  = train_actual_taken_i;
    assign update_bus.actual_target = train_actual_target_i;

    ////////////////////
    // Submodules
    ////////////////////

    // History, handshake and response
    bp_ctrl #(
        .GHR_WIDTH (GHR_WIDTH)
    ) ctrl_i (
        .clock                  (clock),
        .reset                  (reset),
        .predict_valid_i        (predict_valid_i),
        .predict_pc_i           (predict_pc_i),
        .predict_ready_o        (predict_ready_o),
        .predict_resp_valid_o   (predict_resp_valid_o),
        .predict_taken_o        (predict_taken_o),
        .predict_target_o       (predict_target_o),
        .predict_ghr_snapshot_o (predict_ghr_snapshot_o),
        .train_valid_i          (train_valid_i),
        .train_mispredict_i     (train_mispredict_i),
        .train_ghr_snapshot_i   (train_ghr_snapshot_i),
        .train_actual_taken_i   (train_actual_taken_i),
        .lookup                 (lookup_bus.ctrl)
    );

    // Direction counters
    bp_pht #(
        .GHR_WIDTH (GHR_WIDTH),
        .PHT_BITS  (PHT_BITS)
    ) pht_i (
        .clock  (clock),
        .reset  (reset),
        .lookup (lookup_bus.pht),
        .update (update_bus.pht)
    );

    // Target buffer
    bp_btb #(
        .BTB_BITS     (BTB_BITS),
        .BTB_TAG_BITS (BTB_TAG_BITS)
    ) btb_i (
        .clock  (clock),
        .reset  (reset),
        .lookup (lookup_bus.btb),
        .update (update_bus.btb)
    );

endmodule

`default_nettype wire

// ==== project.f ====
bp_pkg.sv
bp_if.sv
bp_ctrl.sv
bp_pht.sv
bp_btb.sv
bp_top.sv
bp_tb.sv
